//--- bp_params.svh
/* branch predictor sizes
   PC, BTB geometry, fetch credits and reset vector shared by the front end */
`ifndef BP_PARAMS_SVH
`define BP_PARAMS_SVH

// address width, bits 1:0 always zero
`define BP_PC_WIDTH 64

// direct mapped BTB geometry
`define BP_BTB_ENTRIES 64
`define BP_BTB_INDEX_W 6

// tag is everything above the index and the word offset
`define BP_TAG_W (`BP_PC_WIDTH - `BP_BTB_INDEX_W - 2)

// decode queue depth, one credit per slot
`define BP_FETCH_CREDITS 4
`define BP_CREDIT_W 3

// two instructions per fetch packet
`define BP_FETCH_BYTES 8

`define BP_RESET_PC 64'h1000

`endif

//--- bp_pkg.sv
/* branch predictor types
   addresses, BTB fields, retire updates, fetch packets and register commands */
`include "bp_params.svh"

package bp_pkg;

	typedef logic [`BP_PC_WIDTH-1:0] pc_t;
	typedef logic [`BP_BTB_INDEX_W-1:0] btb_index_t; // pc[7:2]
	typedef logic [`BP_TAG_W-1:0] btb_tag_t; // pc[63:8]
	typedef logic [`BP_CREDIT_W-1:0] credit_t; // 0..4

	// one retired jump from the ROB
	typedef struct packed {
		logic valid;
		pc_t pc; // branch address
		pc_t target; // resolved target
	} retire_upd_t;

	// packet to the decode queue
	typedef struct packed {
		pc_t pc;
		logic two_wide; // both slots valid
		logic pred_taken;
		pc_t pred_target; // next fetch address
	} fetch_pkt_t;

	// register port command
	typedef struct packed {
		logic write;
		logic addr;
		logic [31:0] wdata;
	} cfg_cmd_t;

	localparam logic CFG_CTRL = 1'b0; // bit 0 enable, bit 1 flush
	localparam logic CFG_TAKEN_CNT = 1'b1; // read only

endpackage

//--- btb.sv
/* btb: direct mapped branch target buffer
   two lookups per cycle (pc, pc+4), trained by two retire ports */
`include "bp_params.svh"

module btb import bp_pkg::*; (
	input logic clock,
	input logic reset,
	input logic flush,
	input retire_upd_t retire0,
	input retire_upd_t retire1,
	input pc_t lookup_pc,
	output logic hit0,
	output logic hit1,
	output pc_t target0,
	output pc_t target1
);

	logic [`BP_BTB_ENTRIES-1:0] valid_q;
	btb_tag_t tag_q [`BP_BTB_ENTRIES];
	pc_t target_q [`BP_BTB_ENTRIES];

	pc_t lookup_pc4; // second slot of the fetch pair
	btb_index_t idx0, idx1; // lookup indices
	btb_index_t wr_idx0, wr_idx1; // retire indices

	function automatic btb_index_t pc_index(input pc_t pc);
		return pc[`BP_BTB_INDEX_W+1:2];
	endfunction

	function automatic btb_tag_t pc_tag(input pc_t pc);
		return pc[`BP_PC_WIDTH-1:`BP_BTB_INDEX_W+2];
	endfunction

	assign lookup_pc4 = lookup_pc + pc_t'(4);
	assign idx0 = pc_index(lookup_pc);
	assign idx1 = pc_index(lookup_pc4);
	assign wr_idx0 = pc_index(retire0.pc);
	assign wr_idx1 = pc_index(retire1.pc);

	// read side, purely combinational so new entries show one cycle after retire
	assign hit0 = valid_q[idx0] && (tag_q[idx0] == pc_tag(lookup_pc));
	assign hit1 = valid_q[idx1] && (tag_q[idx1] == pc_tag(lookup_pc4));
	assign target0 = target_q[idx0];
	assign target1 = target_q[idx1];

	// valid bits, flush beats any allocation in the same cycle
	always_ff @(posedge clock) begin
		if (reset || flush) begin
			valid_q <= '0;
		end else begin
			if (retire0.valid)
				valid_q[wr_idx0] <= 1'b1;
			if (retire1.valid)
				valid_q[wr_idx1] <= 1'b1;
		end
	end

	// tag and target payload
	always_ff @(posedge clock) begin
		if (retire0.valid) begin
			tag_q[wr_idx0] <= pc_tag(retire0.pc);
			target_q[wr_idx0] <= retire0.target;
		end
		// younger branch, written last so it wins on an index clash
		if (retire1.valid) begin
			tag_q[wr_idx1] <= pc_tag(retire1.pc);
			target_q[wr_idx1] <= retire1.target;
		end
	end

	// the ROB only ever resolves to word addresses
	a_retire0_aligned: assert property (@(posedge clock) disable iff (reset)
		retire0.valid |-> retire0.target[1:0] == 2'b00);
	a_retire1_aligned: assert property (@(posedge clock) disable iff (reset)
		retire1.valid |-> retire1.target[1:0] == 2'b00);

	// fetch side never produces an odd pc
	a_lookup_aligned: assert property (@(posedge clock) disable iff (reset)
		lookup_pc[1:0] == 2'b00);

endmodule

//--- fetch_pc_gen.sv
/* fetch pc generator
   picks the next fetch address and sends credit-limited packets to decode */
`include "bp_params.svh"

module fetch_pc_gen import bp_pkg::*; (
	input logic clock,
	input logic reset,
	input logic pred_enable,
	input logic hit0,
	input logic hit1,
	input pc_t target0,
	input pc_t target1,
	input logic redirect_valid,
	input pc_t redirect_pc,
	input logic credit_return,
	output pc_t lookup_pc,
	output logic fetch_valid,
	output fetch_pkt_t fetch_pkt
);

	pc_t pc_q, pc_d;
	credit_t credit_q, credit_d;
	logic running_q; // low while in reset, blocks sends
	logic send;

	assign lookup_pc = pc_q;

	// a redirect cycle never sends, the old pc is dead
	assign send = running_q && (credit_q != '0) && !redirect_valid;
	assign fetch_valid = send;

	// packet build, slot 0 hit cuts the pair short
	always_comb begin
		fetch_pkt.pc = pc_q;
		if (pred_enable && hit0) begin
			fetch_pkt.two_wide = 1'b0;
			fetch_pkt.pred_taken = 1'b1;
			fetch_pkt.pred_target = target0;
		end else if (pred_enable && hit1) begin
			fetch_pkt.two_wide = 1'b1; // slot 1 is the branch
			fetch_pkt.pred_taken = 1'b1;
			fetch_pkt.pred_target = target1;
		end else begin
			fetch_pkt.two_wide = 1'b1;
			fetch_pkt.pred_taken = 1'b0;
			fetch_pkt.pred_target = pc_q + pc_t'(`BP_FETCH_BYTES); // fall through
		end
	end

	// next pc, redirect first
	always_comb begin
		if (redirect_valid)
			pc_d = redirect_pc;
		else if (send)
			pc_d = fetch_pkt.pred_target;
		else
			pc_d = pc_q; // stalled on credits
	end

	// send and return together cancel out
	always_comb begin
		credit_d = credit_q;
		if (send && !credit_return)
			credit_d = credit_q - credit_t'(1);
		else if (!send && credit_return)
			credit_d = credit_q + credit_t'(1);
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			pc_q <= `BP_RESET_PC;
			credit_q <= credit_t'(`BP_FETCH_CREDITS);
			running_q <= 1'b0;
		end else begin
			pc_q <= pc_d;
			credit_q <= credit_d;
			running_q <= 1'b1;
		end
	end

	// decode queue must not return more credits than it was given
	a_credit_max: assert property (@(posedge clock) disable iff (reset)
		credit_q <= credit_t'(`BP_FETCH_CREDITS));

	// zero credits and no return keep the next cycle silent
	a_no_send_empty: assert property (@(posedge clock) disable iff (reset)
		credit_q == '0 && !credit_return |=> !fetch_valid);

endmodule

//--- bp_cfg_regs.sv
/* predictor register block
   enable bit, self-clearing flush and a taken-prediction counter */
module bp_cfg_regs import bp_pkg::*; (
	input logic clock,
	input logic reset,
	input cfg_cmd_t cfg,
	output logic [31:0] cfg_rdata,
	input logic taken_event,
	output logic pred_enable,
	output logic flush
);

	logic enable_q;
	logic flush_q;
	logic [31:0] taken_cnt_q;
	logic ctrl_wr;

	assign ctrl_wr = cfg.write && (cfg.addr == CFG_CTRL);

	always_ff @(posedge clock) begin
		if (reset) begin
			enable_q <= 1'b1; // predict from the start
			flush_q <= 1'b0;
		end else begin
			if (ctrl_wr)
				enable_q <= cfg.wdata[0];
			flush_q <= ctrl_wr && cfg.wdata[1]; // one cycle pulse
		end
	end

	// wraps at 2^32
	always_ff @(posedge clock) begin
		if (reset)
			taken_cnt_q <= '0;
		else if (taken_event)
			taken_cnt_q <= taken_cnt_q + 32'd1;
	end

	// flush is write only and reads as zero
	always_comb begin
		if (cfg.addr == CFG_TAKEN_CNT)
			cfg_rdata = taken_cnt_q;
		else
			cfg_rdata = {31'd0, enable_q};
	end

	assign pred_enable = enable_q;
	assign flush = flush_q;

endmodule

//--- fetch_predict_top.sv
/* fetch prediction top
   register block, BTB and pc generator for the two-wide front end */
module fetch_predict_top import bp_pkg::*; (
	input logic clock,
	input logic reset,
	input retire_upd_t retire0,
	input retire_upd_t retire1,
	input logic redirect_valid,
	input pc_t redirect_pc,
	input logic credit_return,
	input cfg_cmd_t cfg,
	output logic [31:0] cfg_rdata,
	output logic fetch_valid,
	output fetch_pkt_t fetch_pkt
);

	logic pred_enable, flush;
	logic hit0, hit1;
	pc_t target0, target1;
	pc_t lookup_pc;
	logic taken_event;

	// only packets that actually left count as taken
	assign taken_event = fetch_valid && fetch_pkt.pred_taken;

	bp_cfg_regs u_cfg_regs (
		.clock(clock), .reset(reset),
		.cfg(cfg), .cfg_rdata(cfg_rdata),
		.taken_event(taken_event),
		.pred_enable(pred_enable), .flush(flush)
	);

	btb u_btb (
		.clock(clock), .reset(reset), .flush(flush),
		.retire0(retire0), .retire1(retire1),
		.lookup_pc(lookup_pc),
		.hit0(hit0), .hit1(hit1),
		.target0(target0), .target1(target1)
	);

	fetch_pc_gen u_pc_gen (
		.clock(clock), .reset(reset), .pred_enable(pred_enable),
		.hit0(hit0), .hit1(hit1), .target0(target0), .target1(target1),
		.redirect_valid(redirect_valid), .redirect_pc(redirect_pc),
		.credit_return(credit_return), .lookup_pc(lookup_pc),
		.fetch_valid(fetch_valid), .fetch_pkt(fetch_pkt)
	);

endmodule

//--- tb_fetch_predict.sv
/* testbench for the fetch prediction top
   directed tests for sequential fetch, credits, BTB training and the register port */
`include "bp_params.svh"

module tb_fetch_predict import bp_pkg::*;;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int MAX_CYCLES = 2000; // whole run is near 150 cycles

	logic clock = 1'b0;
	logic reset;
	retire_upd_t retire0, retire1;
	logic redirect_valid;
	pc_t redirect_pc;
	logic credit_return;
	cfg_cmd_t cfg;
	logic [31:0] cfg_rdata;
	logic fetch_valid;
	fetch_pkt_t fetch_pkt;

	logic [15:0] lfsr_state;
	int held; // packets sitting in the decode queue model
	int exp_taken; // taken packets the tests expect since the last reset
	bit returns_on; // queue drains one packet per cycle
	int extra_returns; // single returns while draining is off
	int cycle_count;
	pc_t branch_a, target_t; // trained branch, kept for the register test

	fetch_predict_top UUT (.*);

	always #20 clock = ~clock;

	// decode queue model, sampled at the edge so it sees the values of the cycle that ends
	always @(posedge clock) begin
		if (reset) begin
			held = 0;
			credit_return <= 1'b0;
		end else begin
			held = held + int'(fetch_valid) - int'(credit_return);
			if (held > 0 && (returns_on || extra_returns > 0)) begin
				credit_return <= 1'b1;
				if (!returns_on)
					extra_returns = extra_returns - 1;
			end else begin
				credit_return <= 1'b0;
			end
		end
	end

	always @(posedge clock) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > MAX_CYCLES) begin
			$display("timeout: the DUT did not send an expected packet within %0d cycles",
				MAX_CYCLES);
			$display("Test failed");
			$fatal(1);
		end
	end

	// 16 bit Fibonacci LFSR, taps 16 14 13 11, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic fb;
		int i;
		r = '0;
		for (i = 0; i < n; i++) begin
			fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
			lfsr_state = {lfsr_state[14:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	task automatic check_equal(input string test, input string what,
			input logic [63:0] expected, input logic [63:0] actual);
		assert (actual === expected) else begin
			$display("[ERROR] %s %s: expected %h actual %h", test, what, expected, actual);
			$display("Test failed");
			$fatal(1);
		end
	endtask

	task automatic check_pkt(input string test, input fetch_pkt_t pkt, input pc_t pc,
			input logic two_wide, input logic taken, input pc_t target);
		check_equal(test, "pc", pc, pkt.pc);
		check_equal(test, "two_wide", 64'(two_wide), 64'(pkt.two_wide));
		check_equal(test, "pred_taken", 64'(taken), 64'(pkt.pred_taken));
		check_equal(test, "pred_target", target, pkt.pred_target);
		if (taken)
			exp_taken = exp_taken + 1; // one more for the counter read
	endtask

	task automatic apply_reset();
		reset <= 1'b1;
		repeat (5) @(posedge clock);
		reset <= 1'b0;
	endtask

	// next packet that actually leaves, seen mid cycle
	task automatic wait_send(output fetch_pkt_t pkt);
		@(negedge clock);
		while (!fetch_valid)
			@(negedge clock);
		pkt = fetch_pkt;
	endtask

	task automatic redirect_to(input pc_t pc);
		@(posedge clock);
		redirect_valid <= 1'b1;
		redirect_pc <= pc;
		@(posedge clock);
		redirect_valid <= 1'b0;
	endtask

	task automatic retire_pair(input retire_upd_t r0, input retire_upd_t r1);
		@(posedge clock);
		retire0 <= r0;
		retire1 <= r1;
		@(posedge clock);
		retire0 <= '0;
		retire1 <= '0;
	endtask

	task automatic cfg_write(input logic addr, input logic [31:0] data);
		@(posedge clock);
		cfg <= '{write: 1'b1, addr: addr, wdata: data};
		@(posedge clock);
		cfg <= '0;
	endtask

	task automatic test_sequential();
		fetch_pkt_t pkt;
		pc_t exp_pc;
		exp_pc = `BP_RESET_PC;
		wait_send(pkt);
		check_pkt("test_sequential", pkt, exp_pc, 1'b1, 1'b0, exp_pc + 64'd8);
		repeat (8) begin
			exp_pc = exp_pc + 64'd8; // two words per packet
			wait_send(pkt);
			check_pkt("test_sequential", pkt, exp_pc, 1'b1, 1'b0, exp_pc + 64'd8);
		end
	endtask

	task automatic test_credits();
		fetch_pkt_t pkt;
		pc_t exp_pc;
		returns_on = 1'b0;
		@(posedge clock);
		apply_reset(); // back to a full set of credits
		exp_taken = 0; // counter restarts with the DUT
		exp_pc = `BP_RESET_PC;
		repeat (4) begin
			wait_send(pkt);
			check_equal("test_credits", "pc", exp_pc, pkt.pc);
			exp_pc = exp_pc + 64'd8;
		end
		repeat (10) begin
			@(negedge clock);
			check_equal("test_credits", "fetch_valid", 64'd0, 64'(fetch_valid));
			check_equal("test_credits", "held pc", exp_pc, fetch_pkt.pc);
		end
		extra_returns = 1;
		wait_send(pkt);
		check_equal("test_credits", "pc after return", exp_pc, pkt.pc);
		exp_pc = exp_pc + 64'd8;
		repeat (5) begin
			@(negedge clock);
			check_equal("test_credits", "fetch_valid", 64'd0, 64'(fetch_valid));
			check_equal("test_credits", "held pc", exp_pc, fetch_pkt.pc);
		end
		returns_on = 1'b1;
	endtask

	task automatic test_train_slots();
		fetch_pkt_t pkt;
		branch_a = 64'h0010_0000 + (pc_t'(rand_bits(10)) << 2);
		target_t = 64'h0020_0000 + (pc_t'(rand_bits(10)) << 2);
		while (target_t[7:2] == branch_a[7:2])
			target_t = 64'h0020_0000 + (pc_t'(rand_bits(10)) << 2);
		retire_pair('{valid: 1'b1, pc: branch_a, target: target_t}, '0);
		redirect_to(branch_a);
		wait_send(pkt);
		check_pkt("test_train_slots", pkt, branch_a, 1'b0, 1'b1, target_t);
		wait_send(pkt);
		check_equal("test_train_slots", "pc after taken", target_t, pkt.pc);
		redirect_to(branch_a - 64'd4); // branch now in slot 1
		wait_send(pkt);
		check_pkt("test_train_slots", pkt, branch_a - 64'd4, 1'b1, 1'b1, target_t);
	endtask

	task automatic test_dual_retire();
		fetch_pkt_t pkt;
		logic [5:0] idx;
		pc_t b0, b1, u0, u1;
		idx = 6'(rand_bits(6));
		while (idx == branch_a[7:2])
			idx = 6'(rand_bits(6)); // keep the trained entry alive
		b0 = 64'h0030_0000 + {idx, 2'b00};
		b1 = 64'h0040_0000 + {idx, 2'b00}; // same index, other tag
		u0 = 64'h0050_0000 + (pc_t'(rand_bits(10)) << 2);
		u1 = 64'h0060_0000 + (pc_t'(rand_bits(10)) << 2);
		retire_pair('{valid: 1'b1, pc: b0, target: u0}, '{valid: 1'b1, pc: b1, target: u1});
		redirect_to(b1);
		wait_send(pkt);
		check_pkt("test_dual_retire", pkt, b1, 1'b0, 1'b1, u1);
		redirect_to(b0); // older branch lost the entry
		wait_send(pkt);
		check_pkt("test_dual_retire", pkt, b0, 1'b1, 1'b0, b0 + 64'd8);
	endtask

	task automatic test_cfg();
		fetch_pkt_t pkt;
		cfg_write(CFG_CTRL, 32'd0);
		redirect_to(branch_a);
		wait_send(pkt);
		check_pkt("test_cfg", pkt, branch_a, 1'b1, 1'b0, branch_a + 64'd8);
		cfg_write(CFG_CTRL, 32'd1);
		redirect_to(branch_a);
		wait_send(pkt);
		check_pkt("test_cfg", pkt, branch_a, 1'b0, 1'b1, target_t);
		cfg_write(CFG_CTRL, 32'd3); // enable stays, flush pulses
		redirect_to(branch_a);
		wait_send(pkt);
		check_pkt("test_cfg", pkt, branch_a, 1'b1, 1'b0, branch_a + 64'd8);
		@(posedge clock);
		cfg <= '{write: 1'b0, addr: CFG_CTRL, wdata: 32'd0};
		@(negedge clock);
		check_equal("test_cfg", "ctrl read", 64'd1, 64'(cfg_rdata));
		@(posedge clock);
		cfg <= '{write: 1'b0, addr: CFG_TAKEN_CNT, wdata: 32'd0};
		@(negedge clock);
		check_equal("test_cfg", "taken count", 64'(exp_taken), 64'(cfg_rdata));
	endtask

	initial begin
		reset = 1'b1;
		retire0 = '0;
		retire1 = '0;
		redirect_valid = 1'b0;
		redirect_pc = '0;
		credit_return = 1'b0;
		cfg = '0;
		lfsr_state = 16'd18;
		held = 0;
		exp_taken = 0;
		returns_on = 1'b1;
		extra_returns = 0;
		cycle_count = 0;
		apply_reset();
		test_sequential();
		test_credits();
		test_train_slots();
		test_dual_retire();
		test_cfg();
		$display("Test passed");
		$finish;
	end

endmodule

//--- fetch_predict_top.f
+incdir+.
bp_pkg.sv
btb.sv
fetch_pc_gen.sv
bp_cfg_regs.sv
fetch_predict_top.sv
tb_fetch_predict.sv

//--- Bender.yml
package:
  name: fetch_predict

export_include_dirs:
  - .

sources:
  - bp_pkg.sv
  - btb.sv
  - fetch_pc_gen.sv
  - bp_cfg_regs.sv
  - fetch_predict_top.sv
  - target: simulation
    files:
      - tb_fetch_predict.sv
